// File: Bender.yml
package:
  name: execute_stage

sources:
  - target: any(rtl, test)
    files:
      - hw/mipsIsaPkg.sv
      - hw/execPkg.sv
      - hw/aluControl.sv
      - hw/alu32.sv
      - hw/hiLoUnit.sv
      - hw/executeStage.sv
  - target: test
    files:
      - sim/tbExecuteStage.sv

// File: hw/alu32.sv
`timescale 1ns/1ps

module alu32 (
    input  mipsIsaPkg::aluOp_e              aluOp,
    input  logic [execPkg::dataWidth-1:0]   a,
    input  logic [execPkg::dataWidth-1:0]   b,
    input  logic [4:0]                      shiftAmt,  // shamt or a[4:0]
    input  logic [execPkg::dataWidth-1:0]   hi,
    input  logic [execPkg::dataWidth-1:0]   lo,
    output logic [execPkg::dataWidth-1:0]   result,
    output logic                            branchTaken,
    output logic                            regWrite
);

    logic [2*execPkg::dataWidth-1:0] doubled;  // b twice, for rotate
    logic [execPkg::dataWidth-1:0]   mulLow;   // low word same signed or not
    logic                            aNeg;
    logic                            aZero;

    assign doubled = {b, b};
    assign mulLow  = a * b;
    assign aNeg    = a[execPkg::dataWidth-1];
    assign aZero   = (a == '0);

    ////////////////////////////////////////////////////////////////////////////
    // result and flags
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        result      = '0;
        branchTaken = 1'b0;
        regWrite    = 1'b1;  // most ops write rd
        case (aluOp)
            mipsIsaPkg::aluAdd:  result = a + b;  // also ld/st address
            mipsIsaPkg::aluSub:  result = a - b;
            mipsIsaPkg::aluAnd:  result = a & b;
            mipsIsaPkg::aluOr:   result = a | b;
            mipsIsaPkg::aluNor:  result = ~(a | b);
            mipsIsaPkg::aluXor:  result = a ^ b;
            mipsIsaPkg::aluLui:  result = {b[15:0], 16'h0000};
            mipsIsaPkg::aluSll:  result = b << shiftAmt;
            mipsIsaPkg::aluSrl:  result = b >> shiftAmt;
            mipsIsaPkg::aluSra:  result = $signed(b) >>> shiftAmt;  // sign fill
            mipsIsaPkg::aluRotr: result = doubled[shiftAmt +: execPkg::dataWidth];
            mipsIsaPkg::aluSlt: begin
                result = {{(execPkg::dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
            end
            mipsIsaPkg::aluSltu: begin
                result = {{(execPkg::dataWidth-1){1'b0}}, a < b};
            end
            mipsIsaPkg::aluMovn: begin
                result   = a;
                regWrite = (b != '0);  // write only if rt nonzero
            end
            mipsIsaPkg::aluMovz: begin
                result   = a;
                regWrite = (b == '0);
            end
            mipsIsaPkg::aluMfhi: result = hi;
            mipsIsaPkg::aluMflo: result = lo;
            mipsIsaPkg::aluMul:  result = mulLow;
            mipsIsaPkg::aluSeb:  result = {{24{b[7]}}, b[7:0]};
            mipsIsaPkg::aluSeh:  result = {{16{b[15]}}, b[15:0]};
            mipsIsaPkg::aluBeq: begin
                regWrite    = 1'b0;
                branchTaken = (a == b);
            end
            mipsIsaPkg::aluBne: begin
                regWrite    = 1'b0;
                branchTaken = (a != b);
            end
            mipsIsaPkg::aluBgtz: begin
                regWrite    = 1'b0;
                branchTaken = !aNeg && !aZero;  // signed a > 0
            end
            mipsIsaPkg::aluBlez: begin
                regWrite    = 1'b0;
                branchTaken = aNeg || aZero;
            end
            mipsIsaPkg::aluBgez: begin
                regWrite    = 1'b0;
                branchTaken = !aNeg;
            end
            mipsIsaPkg::aluBltz: begin
                regWrite    = 1'b0;
                branchTaken = aNeg;
            end
            mipsIsaPkg::aluMult, mipsIsaPkg::aluMultu, mipsIsaPkg::aluMadd,
            mipsIsaPkg::aluMsub, mipsIsaPkg::aluMthi, mipsIsaPkg::aluMtlo,
            mipsIsaPkg::aluNop: begin
                regWrite = 1'b0;  // hi/lo unit takes these, no rd write
            end
        endcase
    end

endmodule

// File: hw/aluControl.sv
`timescale 1ns/1ps

module aluControl (
    input  mipsIsaPkg::opcode_e opcode,
    input  logic [5:0]          funct,
    input  logic [4:0]          rtField,
    input  logic [4:0]          shamt,
    output mipsIsaPkg::aluOp_e  aluOp,
    output logic                useShamt
);

    always_comb begin
        aluOp    = mipsIsaPkg::aluNop;  // unknown encodings fall out as nop
        useShamt = 1'b0;
        case (opcode)
            mipsIsaPkg::opSpecial: begin
                case (funct)
                    mipsIsaPkg::functSll: begin
                        aluOp    = mipsIsaPkg::aluSll;
                        useShamt = 1'b1;
                    end
                    mipsIsaPkg::functSrl: begin
                        aluOp    = mipsIsaPkg::aluSrl;
                        useShamt = 1'b1;
                    end
                    mipsIsaPkg::functSra: begin
                        aluOp    = mipsIsaPkg::aluSra;
                        useShamt = 1'b1;
                    end
                    mipsIsaPkg::functRotr: begin
                        aluOp    = mipsIsaPkg::aluRotr;
                        useShamt = 1'b1;
                    end
                    mipsIsaPkg::functSllv: aluOp = mipsIsaPkg::aluSll;  // amount from a[4:0]
                    mipsIsaPkg::functSrlv: begin
                        aluOp = (shamt == mipsIsaPkg::saRotrv) ? mipsIsaPkg::aluRotr
                                                               : mipsIsaPkg::aluSrl;
                    end
                    mipsIsaPkg::functSrav:  aluOp = mipsIsaPkg::aluSra;
                    mipsIsaPkg::functMovz:  aluOp = mipsIsaPkg::aluMovz;
                    mipsIsaPkg::functMovn:  aluOp = mipsIsaPkg::aluMovn;
                    mipsIsaPkg::functMfhi:  aluOp = mipsIsaPkg::aluMfhi;
                    mipsIsaPkg::functMthi:  aluOp = mipsIsaPkg::aluMthi;
                    mipsIsaPkg::functMflo:  aluOp = mipsIsaPkg::aluMflo;
                    mipsIsaPkg::functMtlo:  aluOp = mipsIsaPkg::aluMtlo;
                    mipsIsaPkg::functMult:  aluOp = mipsIsaPkg::aluMult;
                    mipsIsaPkg::functMultu: aluOp = mipsIsaPkg::aluMultu;
                    mipsIsaPkg::functAdd,
                    mipsIsaPkg::functAddu:  aluOp = mipsIsaPkg::aluAdd;  // no overflow trap
                    mipsIsaPkg::functSub,
                    mipsIsaPkg::functSubu:  aluOp = mipsIsaPkg::aluSub;
                    mipsIsaPkg::functAnd:   aluOp = mipsIsaPkg::aluAnd;
                    mipsIsaPkg::functOr:    aluOp = mipsIsaPkg::aluOr;
                    mipsIsaPkg::functXor:   aluOp = mipsIsaPkg::aluXor;
                    mipsIsaPkg::functNor:   aluOp = mipsIsaPkg::aluNor;
                    mipsIsaPkg::functSlt:   aluOp = mipsIsaPkg::aluSlt;
                    mipsIsaPkg::functSltu:  aluOp = mipsIsaPkg::aluSltu;
                    default:                aluOp = mipsIsaPkg::aluNop;  // jr and friends
                endcase
            end
            mipsIsaPkg::opSpecial2: begin
                if (funct == mipsIsaPkg::functMul)       aluOp = mipsIsaPkg::aluMul;
                else if (funct == mipsIsaPkg::functMadd) aluOp = mipsIsaPkg::aluMadd;
                else if (funct == mipsIsaPkg::functMsub) aluOp = mipsIsaPkg::aluMsub;
            end
            mipsIsaPkg::opSpecial3: begin
                if (funct == mipsIsaPkg::functBshfl) begin
                    if (shamt == mipsIsaPkg::saSeb)      aluOp = mipsIsaPkg::aluSeb;
                    else if (shamt == mipsIsaPkg::saSeh) aluOp = mipsIsaPkg::aluSeh;
                end
            end
            mipsIsaPkg::opRegimm: begin
                if (rtField == mipsIsaPkg::rtBgez)      aluOp = mipsIsaPkg::aluBgez;
                else if (rtField == mipsIsaPkg::rtBltz) aluOp = mipsIsaPkg::aluBltz;
            end
            mipsIsaPkg::opBeq:  aluOp = mipsIsaPkg::aluBeq;
            mipsIsaPkg::opBne:  aluOp = mipsIsaPkg::aluBne;
            mipsIsaPkg::opBlez: aluOp = mipsIsaPkg::aluBlez;
            mipsIsaPkg::opBgtz: aluOp = mipsIsaPkg::aluBgtz;
            mipsIsaPkg::opAddi,
            mipsIsaPkg::opAddiu: aluOp = mipsIsaPkg::aluAdd;
            mipsIsaPkg::opSlti:  aluOp = mipsIsaPkg::aluSlt;
            mipsIsaPkg::opSltiu: aluOp = mipsIsaPkg::aluSltu;
            mipsIsaPkg::opAndi:  aluOp = mipsIsaPkg::aluAnd;
            mipsIsaPkg::opOri:   aluOp = mipsIsaPkg::aluOr;
            mipsIsaPkg::opXori:  aluOp = mipsIsaPkg::aluXor;
            mipsIsaPkg::opLui:   aluOp = mipsIsaPkg::aluLui;
            mipsIsaPkg::opLb, mipsIsaPkg::opLh, mipsIsaPkg::opLw,
            mipsIsaPkg::opSb, mipsIsaPkg::opSh, mipsIsaPkg::opSw: begin
                aluOp = mipsIsaPkg::aluAdd;  // effective address only
            end
            mipsIsaPkg::opJ,
            mipsIsaPkg::opJal:   aluOp = mipsIsaPkg::aluNop;  // jumps handled elsewhere
            default:             aluOp = mipsIsaPkg::aluNop;
        endcase
    end

endmodule

// File: hw/execPkg.sv
package execPkg;

    localparam int dataWidth  = 32;  // data word
    localparam int codeWidth  = 6;   // opcode and funct
    localparam int fieldWidth = 5;   // rt and shamt fields

    ////////////////////////////////////////////////////////////////////////////
    // execute stage request / result
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;    // one instruction this cycle
        logic [codeWidth-1:0]  opcode;
        logic [codeWidth-1:0]  funct;
        logic [fieldWidth-1:0] rtField;  // regimm branch select
        logic [fieldWidth-1:0] shamt;
        logic [dataWidth-1:0]  a;        // rs value
        logic [dataWidth-1:0]  b;        // rt or extended imm
    } execReq_t;

    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] result;
        logic                 branchTaken;
        logic                 regWrite;
    } execRes_t;

endpackage

// File: hw/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic              clk,
    input  logic              rst,
    input  execPkg::execReq_t req,
    output execPkg::execRes_t res
);

    mipsIsaPkg::aluOp_e              aluOp;
    logic                            useShamt;
    logic [4:0]                      shiftAmt;
    logic [execPkg::dataWidth-1:0]   aluResult;
    logic                            aluBranch;
    logic                            aluRegWrite;
    logic [execPkg::dataWidth-1:0]   hi;
    logic [execPkg::dataWidth-1:0]   lo;

    aluControl u_aluControl (
        .opcode   (mipsIsaPkg::opcode_e'(req.opcode)),
        .funct    (req.funct),
        .rtField  (req.rtField),
        .shamt    (req.shamt),
        .aluOp    (aluOp),
        .useShamt (useShamt)
    );

    assign shiftAmt = useShamt ? req.shamt : req.a[4:0];  // fixed vs variable shift

    alu32 u_alu32 (
        .aluOp       (aluOp),
        .a           (req.a),
        .b           (req.b),
        .shiftAmt    (shiftAmt),
        .hi          (hi),
        .lo          (lo),
        .result      (aluResult),
        .branchTaken (aluBranch),
        .regWrite    (aluRegWrite)
    );

    hiLoUnit u_hiLoUnit (
        .clk   (clk),
        .rst   (rst),
        .valid (req.valid),
        .aluOp (aluOp),
        .a     (req.a),
        .b     (req.b),
        .hi    (hi),
        .lo    (lo)
    );

    ////////////////////////////////////////////////////////////////////////////
    // one-cycle output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        res.result <= req.valid ? aluResult : '0;  // idle cycle shows zero
        if (rst) begin
            res.valid       <= 1'b0;
            res.branchTaken <= 1'b0;
            res.regWrite    <= 1'b0;
        end else begin
            res.valid       <= req.valid;
            res.branchTaken <= req.valid & aluBranch;    // no flags on idle
            res.regWrite    <= req.valid & aluRegWrite;
        end
    end

endmodule

// File: hw/hiLoUnit.sv
`timescale 1ns/1ps

module hiLoUnit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            valid,
    input  mipsIsaPkg::aluOp_e              aluOp,
    input  logic [execPkg::dataWidth-1:0]   a,
    input  logic [execPkg::dataWidth-1:0]   b,
    output logic [execPkg::dataWidth-1:0]   hi,
    output logic [execPkg::dataWidth-1:0]   lo
);

    logic [2*execPkg::dataWidth-1:0] signedProd;    // rs * rt as two's complement
    logic [2*execPkg::dataWidth-1:0] unsignedProd;
    logic [2*execPkg::dataWidth-1:0] acc;           // current {hi, lo}

    assign signedProd = $signed({{execPkg::dataWidth{a[execPkg::dataWidth-1]}}, a})
                      * $signed({{execPkg::dataWidth{b[execPkg::dataWidth-1]}}, b});
    assign unsignedProd = {{execPkg::dataWidth{1'b0}}, a} * {{execPkg::dataWidth{1'b0}}, b};
    assign acc = {hi, lo};

    ////////////////////////////////////////////////////////////////////////////
    // hi/lo registers, written at the edge the op is sampled
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (valid) begin
            case (aluOp)
                mipsIsaPkg::aluMult:  {hi, lo} <= signedProd;
                mipsIsaPkg::aluMultu: {hi, lo} <= unsignedProd;
                mipsIsaPkg::aluMadd:  {hi, lo} <= acc + signedProd;  // 64-bit accumulate
                mipsIsaPkg::aluMsub:  {hi, lo} <= acc - signedProd;
                mipsIsaPkg::aluMthi:  hi <= a;  // lo untouched
                mipsIsaPkg::aluMtlo:  lo <= a;
                default: begin
                    hi <= hi;  // every other op leaves the pair alone
                    lo <= lo;
                end
            endcase
        end
    end

endmodule

// File: hw/mipsIsaPkg.sv
package mipsIsaPkg;

    ////////////////////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        opSpecial  = 6'b000000,  // r-type, decoded by funct
        opRegimm   = 6'b000001,  // bgez / bltz by rt field
        opJ        = 6'b000010,
        opJal      = 6'b000011,
        opBeq      = 6'b000100,
        opBne      = 6'b000101,
        opBlez     = 6'b000110,
        opBgtz     = 6'b000111,
        opAddi     = 6'b001000,
        opAddiu    = 6'b001001,
        opSlti     = 6'b001010,
        opSltiu    = 6'b001011,
        opAndi     = 6'b001100,
        opOri      = 6'b001101,
        opXori     = 6'b001110,
        opLui      = 6'b001111,
        opSpecial2 = 6'b011100,  // mul, madd, msub
        opSpecial3 = 6'b011111,  // seb, seh
        opLb       = 6'b100000,
        opLh       = 6'b100001,
        opLw       = 6'b100011,
        opSb       = 6'b101000,
        opSh       = 6'b101001,
        opSw       = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        functSll   = 6'b000000,
        functRotr  = 6'b000001,  // rs field not routed here so rotr gets its own code
        functSrl   = 6'b000010,
        functSra   = 6'b000011,
        functSllv  = 6'b000100,
        functSrlv  = 6'b000110,  // rotrv when shamt field is 00001
        functSrav  = 6'b000111,
        functMovz  = 6'b001010,
        functMovn  = 6'b001011,
        functMfhi  = 6'b010000,
        functMthi  = 6'b010001,
        functMflo  = 6'b010010,
        functMtlo  = 6'b010011,
        functMult  = 6'b011000,
        functMultu = 6'b011001,
        functAdd   = 6'b100000,
        functAddu  = 6'b100001,
        functSub   = 6'b100010,
        functSubu  = 6'b100011,
        functAnd   = 6'b100100,
        functOr    = 6'b100101,
        functXor   = 6'b100110,
        functNor   = 6'b100111,
        functSlt   = 6'b101010,
        functSltu  = 6'b101011
    } funct_e;

    // SPECIAL2 / SPECIAL3 reuse funct values already taken above
    localparam funct_e functMadd  = funct_e'(6'b000000);
    localparam funct_e functMul   = funct_e'(6'b000010);
    localparam funct_e functMsub  = funct_e'(6'b000100);
    localparam funct_e functBshfl = funct_e'(6'b100000);  // seb/seh family

    localparam logic [4:0] saSeb   = 5'b10000;  // shamt field under BSHFL
    localparam logic [4:0] saSeh   = 5'b11000;
    localparam logic [4:0] saRotrv = 5'b00001;  // srlv -> rotrv

    typedef enum logic [4:0] {
        rtBltz = 5'b00000,
        rtBgez = 5'b00001
    } regimmRt_e;

    ////////////////////////////////////////////////////////////////////////////
    // alu operations, 33 of them so the field is 6 bits
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluNor, aluXor, aluLui,  // arith / logic
        aluSll, aluSrl, aluSra, aluRotr,                        // shifts
        aluSlt, aluSltu,                                        // compares
        aluMovn, aluMovz,                                       // conditional moves
        aluMfhi, aluMflo,                                       // hi/lo reads
        aluMul, aluSeb, aluSeh,
        aluBeq, aluBne, aluBgtz, aluBlez, aluBgez, aluBltz,     // branches
        aluMult, aluMultu, aluMadd, aluMsub, aluMthi, aluMtlo,  // hi/lo writes
        aluNop
    } aluOp_e;

endpackage

// File: sim.f
hw/mipsIsaPkg.sv
hw/execPkg.sv
hw/aluControl.sv
hw/alu32.sv
hw/hiLoUnit.sv
hw/executeStage.sv
sim/tbExecuteStage.sv

// File: sim/execVectors.txt
# num valid opcode funct rt shamt a b | expected result branchTaken regWrite
# all fields hex, one instruction per line, valid 0 marks an idle cycle
01 1 00 10 00 00 00000000 00000000 00000000 0 1
02 1 00 12 00 00 00000000 00000000 00000000 0 1
03 1 00 20 00 00 7fffffff 00000001 80000000 0 1
04 1 00 22 00 00 00000005 00000007 fffffffe 0 1
05 1 00 24 00 00 f0f0ff00 0ff0f0f0 00f0f000 0 1
06 1 00 25 00 00 f0f0ff00 0ff0f0f0 fff0fff0 0 1
07 1 00 27 00 00 f0f0ff00 0ff0f0f0 000f000f 0 1
08 1 00 26 00 00 f0f0ff00 0ff0f0f0 ff000ff0 0 1
09 1 08 00 00 00 00000010 fffffffc 0000000c 0 1
0a 1 0c 00 00 00 12345678 0000ff00 00005600 0 1
0b 1 0d 00 00 00 12340000 00005678 12345678 0 1
0c 1 0e 00 00 00 ffff0000 0000ffff ffffffff 0 1
0d 1 23 00 00 00 10000000 fffffff8 0ffffff8 0 1
0e 1 2b 00 00 00 00001000 00000024 00001024 0 1
0f 1 0f 00 00 00 00000000 00001234 12340000 0 1
10 1 1f 20 00 10 00000000 00000080 ffffff80 0 1
11 1 1f 20 00 10 00000000 1234567f 0000007f 0 1
12 1 1f 20 00 18 00000000 00008001 ffff8001 0 1
13 1 1f 20 00 18 00000000 ffff7fff 00007fff 0 1
14 1 00 00 00 04 00000000 8000000f 000000f0 0 1
15 1 00 02 00 04 00000000 80000000 08000000 0 1
16 1 00 03 00 04 0000001f 80000000 f8000000 0 1
17 1 00 04 00 00 00000023 00000001 00000008 0 1
18 1 00 06 00 00 00000004 f0000000 0f000000 0 1
19 1 00 07 00 00 00000008 80000000 ff800000 0 1
1a 1 00 01 00 08 00000000 12345678 78123456 0 1
1b 1 00 01 00 00 00000000 12345678 12345678 0 1
1c 1 00 06 00 01 00000004 12345678 81234567 0 1
1d 1 00 2a 00 00 ffffffff 00000001 00000001 0 1
1e 1 00 2b 00 00 ffffffff 00000001 00000000 0 1
1f 1 0a 00 00 00 00000001 ffffffff 00000000 0 1
20 1 0b 00 00 00 00000001 ffffffff 00000001 0 1
21 1 04 00 00 00 00000005 00000005 00000000 1 0
22 1 04 00 00 00 00000005 00000006 00000000 0 0
23 1 05 00 00 00 00000005 00000006 00000000 1 0
24 1 05 00 00 00 00000005 00000005 00000000 0 0
25 1 07 00 00 00 00000001 00000000 00000000 1 0
26 1 07 00 00 00 00000000 00000000 00000000 0 0
27 1 06 00 00 00 ffffffff 00000000 00000000 1 0
28 1 06 00 00 00 00000000 00000000 00000000 1 0
29 1 06 00 00 00 00000001 00000000 00000000 0 0
2a 1 01 00 01 00 00000000 00000000 00000000 1 0
2b 1 01 00 01 00 ffffffff 00000000 00000000 0 0
2c 1 01 00 00 00 80000000 00000000 00000000 1 0
2d 1 01 00 00 00 00000000 00000000 00000000 0 0
2e 1 00 0b 00 00 aaaa5555 00000001 aaaa5555 0 1
2f 1 00 0b 00 00 aaaa5555 00000000 aaaa5555 0 0
30 1 00 0a 00 00 aaaa5555 00000000 aaaa5555 0 1
31 1 00 0a 00 00 aaaa5555 00000002 aaaa5555 0 0
32 0 00 20 00 00 00000001 00000002 00000000 0 0
33 1 00 11 00 00 11223344 00000000 00000000 0 0
34 1 00 13 00 00 55667788 00000000 00000000 0 0
35 1 00 10 00 00 00000000 00000000 11223344 0 1
36 1 00 12 00 00 00000000 00000000 55667788 0 1
37 1 00 18 00 00 fffffffe fffffffd 00000000 0 0
38 1 00 10 00 00 00000000 00000000 00000000 0 1
39 1 00 12 00 00 00000000 00000000 00000006 0 1
3a 1 00 19 00 00 fffffffe fffffffd 00000000 0 0
3b 1 00 10 00 00 00000000 00000000 fffffffb 0 1
3c 1 00 12 00 00 00000000 00000000 00000006 0 1
3d 1 1c 00 00 00 ffffffff 00000002 00000000 0 0
3e 1 00 10 00 00 00000000 00000000 fffffffb 0 1
3f 1 00 12 00 00 00000000 00000000 00000004 0 1
40 1 1c 04 00 00 00010000 00010000 00000000 0 0
41 1 00 10 00 00 00000000 00000000 fffffffa 0 1
42 1 00 12 00 00 00000000 00000000 00000004 0 1
43 1 1c 02 00 00 fffffffe 00000003 fffffffa 0 1
44 1 02 00 00 00 00000000 00000000 00000000 0 0
45 0 00 00 00 00 00000000 00000000 00000000 0 0

// File: sim/tbExecuteStage.sv
`timescale 1ns/1ps

module tbExecuteStage;

    localparam int maxVectors = 128;                  // room in the vector table
    localparam int clkPeriod  = 100;                  // ns

    logic              clk;
    logic              rst;
    execPkg::execReq_t req;
    execPkg::execRes_t res;

    execPkg::execReq_t vecReq [maxVectors];           // stimulus per vector
    execPkg::execRes_t vecExp [maxVectors];           // expected outcome per vector
    logic [31:0]       vecNum [maxVectors];           // test number from the file
    int                numVectors;
    int                passCount;
    int                failCount;

    executeStage u_executeStage (
        .clk (clk),
        .rst (rst),
        .req (req),
        .res (res)
    );

    always #(clkPeriod/2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // vector file
    ////////////////////////////////////////////////////////////////////////////

    task automatic loadVectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] num, vld, op, fn, rt, sa, opA, opB, rslt, br, wr;
        fd = $fopen("sim/execVectors.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open sim/execVectors.txt");
        end else begin
            while (!$feof(fd) && numVectors < maxVectors) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin  // skip header and blanks
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                                num, vld, op, fn, rt, sa, opA, opB, rslt, br, wr);
                    if (n == 11) begin
                        vecNum[numVectors]                 = num;
                        vecReq[numVectors].valid           = vld[0];
                        vecReq[numVectors].opcode          = op[5:0];
                        vecReq[numVectors].funct           = fn[5:0];
                        vecReq[numVectors].rtField         = rt[4:0];
                        vecReq[numVectors].shamt           = sa[4:0];
                        vecReq[numVectors].a               = opA;
                        vecReq[numVectors].b               = opB;
                        vecExp[numVectors].valid           = vld[0];  // one out per one in
                        vecExp[numVectors].result          = rslt;
                        vecExp[numVectors].branchTaken     = br[0];
                        vecExp[numVectors].regWrite        = wr[0];
                        numVectors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // response check, one vector
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkVector(input int idx);
        int errs;
        errs = 0;
        if (res.valid !== vecExp[idx].valid) begin
            if (vecExp[idx].valid) begin
                $display("error: test %0h produced no valid output at %0t", vecNum[idx], $time);
            end else begin
                $display("mismatch at %0t: test %0h valid expected 0 got %b",
                         $time, vecNum[idx], res.valid);
            end
            errs++;
        end
        if (res.result !== vecExp[idx].result) begin
            $display("mismatch at %0t: test %0h result expected %h got %h",
                     $time, vecNum[idx], vecExp[idx].result, res.result);
            errs++;
        end
        if (res.branchTaken !== vecExp[idx].branchTaken) begin
            $display("mismatch at %0t: test %0h branchTaken expected %b got %b",
                     $time, vecNum[idx], vecExp[idx].branchTaken, res.branchTaken);
            errs++;
        end
        if (res.regWrite !== vecExp[idx].regWrite) begin
            $display("mismatch at %0t: test %0h regWrite expected %b got %b",
                     $time, vecNum[idx], vecExp[idx].regWrite, res.regWrite);
            errs++;
        end
        if (errs == 0) begin
            passCount++;
            $display("test %0h passed", vecNum[idx]);
        end else begin
            failCount++;
            $display("test %0h failed with %0d errors", vecNum[idx], errs);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        req        = '0;
        numVectors = 0;
        passCount  = 0;
        failCount  = 0;
        loadVectors();
        if (numVectors == 0) begin
            $display("error: no vectors were read");
            failCount++;
        end else begin
            req = vecReq[0];                          // valid op on the bus, reset must drop it
            repeat (3) @(posedge clk);                // three reset edges
            #2;
            rst = 1'b0;
            if (res.valid !== 1'b0 || res.branchTaken !== 1'b0 || res.regWrite !== 1'b0) begin
                $display("mismatch at %0t: reset left valid %b branchTaken %b regWrite %b",
                         $time, res.valid, res.branchTaken, res.regWrite);
                failCount++;
            end else begin
                passCount++;
                $display("reset test passed");
            end
            for (int i = 0; i < numVectors; i++) begin
                req = vecReq[i];                      // 2 ns after the edge
                @(posedge clk);
                #1;
                checkVector(i);                       // result of the edge just passed
                #1;
            end
            req = '0;
        end
        $display("summary: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog, sized from the vector count
    initial begin
        wait (numVectors > 0);
        #((numVectors + 10) * clkPeriod);
        $display("error: timeout, run did not end within %0d cycles", numVectors + 10);
        $display("Verification failed");
        $finish;
    end

endmodule
